// ==== dv/fpu_exec_sva.sv ====
module fpu_exec_sva #(
    parameter int N_EU = 2
) (
    input logic                 clk_i,
    input logic                 rst_n_i,
    input logic                 flush_i,
    input logic                 issue_valid_i,
    input fpu_pkg::fpu_issue_t  issue_i,
    input logic                 issue_ready_i,
    input logic                 res_valid_i,
    input fpu_pkg::fpu_result_t res_i,
    input logic                 res_ready_i,
    input logic [N_EU-1:0]      disp_valid_i
);

    // Stalled issue keeps valid and payload
    a_issue_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
        issue_valid_i && !issue_ready_i |=> issue_valid_i && $stable(issue_i))
        else $error("issue port changed while stalled");

    // Stalled result slot holds its value
    a_res_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
        res_valid_i && !res_ready_i |=> res_valid_i && $stable(res_i))
        else $error("result port changed while stalled");

    // Dispatch targets one unit at most
    a_disp_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(disp_valid_i))
        else $error("more than one dispatch valid bit set");

    // Output slot empty right after a flush
    a_flush_clear: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> !res_valid_i)
        else $error("result valid in the cycle after a flush");

    // Reset state
    a_reset_state: assert property (@(posedge clk_i)
        !rst_n_i |=> issue_ready_i && !res_valid_i && (disp_valid_i == '0))
        else $error("wrong handshake state after reset");

endmodule

bind fpu_exec_top fpu_exec_sva #(
    .N_EU (N_EU)
) u_sva (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .issue_valid_i (issue_valid_i),
    .issue_i       (issue_i),
    .issue_ready_i (issue_ready_o),
    .res_valid_i   (res_valid_o),
    .res_i         (res_o),
    .res_ready_i   (res_ready_i),
    .disp_valid_i  (disp_valid)
);

// ==== dv/fpu_exec_tb.sv ====
module fpu_exec_tb;

    localparam int RS_DEPTH = 4;
    localparam int N_EU     = 2;
    localparam int N_VEC    = 64;
    localparam int TAGS     = 1 << fpu_pkg::TAG_W;
    localparam int WAIT_MAX = 200;

    logic                 clk_i;
    logic                 rst_n_i;
    logic                 flush_i;
    logic                 issue_valid_i;
    fpu_pkg::fpu_issue_t  issue_i;
    logic                 issue_ready_o;
    logic                 res_valid_o;
    fpu_pkg::fpu_result_t res_o;
    logic                 res_ready_i = 1'b0;

    // Record fields: kind, op, rs1, rs2, tag, expected value, expected invalid
    logic [111:0] vec_mem [N_VEC];

    // Scoreboard, one slot per tag
    logic [31:0]  exp_val [TAGS];
    logic         exp_inv [TAGS];
    logic         live    [TAGS];
    int           n_live;

    // Expected response of the op now on the issue port
    logic [31:0]  cur_val;
    logic         cur_inv;

    logic         issue_taken = 1'b0;
    logic         idle_check;
    logic         timed_out;
    logic [31:0]  rng_state = 32'd4231;
    int           checks = 0;
    int           errors = 0;

    fpu_exec_top #(.RS_DEPTH (RS_DEPTH), .N_EU (N_EU)) DUT (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .issue_ready_o (issue_ready_o),
        .res_valid_o   (res_valid_o),
        .res_o         (res_o),
        .res_ready_i   (res_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #20 clk_i = ~clk_i;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %08h, expected %08h", name, got, exp);
        end
    endtask

    task automatic note_timeout(input string what);
        timed_out = 1'b1;
        $display("Timeout: %s", what);
    endtask

    // Random back-pressure on the result port
    always @(negedge clk_i) begin
        rng_state   = xorshift(rng_state);
        res_ready_i = rng_state[0];
    end

    // Handshakes seen with the values from before the edge
    always @(posedge clk_i) begin
        issue_taken = rst_n_i && issue_valid_i && issue_ready_o;
        if (idle_check) begin
            compare("issue_ready_o", 32'(issue_ready_o), 32'd1);
            compare("res_valid_o", 32'(res_valid_o), 32'd0);
        end
        if (rst_n_i && res_valid_o && res_ready_i) begin
            if (!live[res_o.tag]) begin
                errors++;
                $display("Result with tag %0h arrived but no op with that tag is in flight",
                         res_o.tag);
            end else begin
                compare($sformatf("res_o.value tag %0h", res_o.tag), res_o.value,
                        exp_val[res_o.tag]);
                compare($sformatf("res_o.invalid tag %0h", res_o.tag), 32'(res_o.invalid),
                        32'(exp_inv[res_o.tag]));
                live[res_o.tag] = 1'b0;
                n_live--;
            end
        end
        // A flush kills every tag in flight
        if (!rst_n_i || flush_i) begin
            for (int i = 0; i < TAGS; i++) begin
                live[i] = 1'b0;
            end
            n_live = 0;
        end else if (issue_taken) begin
            live[issue_i.tag]    = 1'b1;
            exp_val[issue_i.tag] = cur_val;
            exp_inv[issue_i.tag] = cur_inv;
            n_live++;
        end
    end

    // Offer one op and hold it until the queue takes it
    task automatic send(input logic [111:0] rec);
        int n;
        n = 0;
        // Tag reuse waits for the earlier op with that tag
        while (live[rec[39:36]] && n < WAIT_MAX) begin
            @(negedge clk_i);
            n++;
        end
        if (live[rec[39:36]]) begin
            note_timeout("tag never came back, so it could not be issued again");
        end else begin
            issue_i.op      = fpu_pkg::fpu_op_e'(rec[106:104]);
            issue_i.rs1.raw = rec[103:72];
            issue_i.rs2.raw = rec[71:40];
            issue_i.tag     = rec[39:36];
            cur_val         = rec[35:4];
            cur_inv         = rec[0];
            issue_valid_i   = 1'b1;
            n = 0;
            @(negedge clk_i);
            while (!issue_taken && n < WAIT_MAX) begin
                @(negedge clk_i);
                n++;
            end
            issue_valid_i = 1'b0;
            if (!issue_taken) begin
                note_timeout("issue port never accepted the op");
            end
        end
    endtask

    task automatic pulse_flush();
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
    endtask

    // Wait until every live tag has returned
    task automatic drain();
        int n;
        n = 0;
        while (n_live != 0 && n < WAIT_MAX) begin
            @(negedge clk_i);
            n++;
        end
        if (n_live != 0) begin
            note_timeout("results still missing at the end of a test");
        end
    endtask

    initial begin
        logic [111:0] rec;
        int           idx;
        int           test_no;
        int           mark_checks;
        int           mark_errors;
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        cur_val       = '0;
        cur_inv       = 1'b0;
        idle_check    = 1'b0;
        timed_out     = 1'b0;
        $readmemh("dv/fpu_testdata.hex", vec_mem);
        repeat (16) @(negedge clk_i);
        rst_n_i = 1'b1;
        // Idle after reset, nothing may show up on the result bus
        idle_check = 1'b1;
        repeat (6) @(negedge clk_i);
        idle_check = 1'b0;
        $display("test 0 finished: %0d checks, %0d errors", checks, errors);
        test_no     = 1;
        mark_checks = checks;
        mark_errors = errors;
        idx         = 0;
        while (idx < N_VEC && !timed_out) begin
            rec = vec_mem[idx];
            idx++;
            case (rec[111:108])
                4'h0: send(rec);
                4'h1: pulse_flush();
                4'h2: begin
                    drain();
                    $display("test %0d finished: %0d checks, %0d errors", test_no,
                             checks - mark_checks, errors - mark_errors);
                    test_no++;
                    mark_checks = checks;
                    mark_errors = errors;
                end
                // End marker
                default: idx = N_VEC;
            endcase
        end
        // Late strays from flushed tags would still be caught here
        repeat (8) @(negedge clk_i);
        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/fpu_testdata.hex ====
// Columns: kind_op_rs1_rs2_tag_expected_invalid, all hex
// Kind 0 issue, 1 flush, 2 end of test, f end of data
// Sign injection
0_0_3f800000_c0000000_0_bf800000_0
0_1_3f800000_c0000000_1_3f800000_0
0_2_bf800000_c0000000_2_3f800000_0
0_1_7f800001_3f800000_3_ff800001_0
2_0_00000000_00000000_0_00000000_0
// Min and max with NaNs and signed zeros
0_3_3f800000_40000000_4_3f800000_0
0_4_bf800000_c0000000_5_bf800000_0
0_3_00000000_80000000_6_80000000_0
0_4_80000000_00000000_7_00000000_0
0_3_7fc00000_40000000_8_40000000_0
0_4_7f800001_c0000000_9_c0000000_1
0_3_7fc00000_ffc00000_a_7fc00000_0
2_0_00000000_00000000_0_00000000_0
// Compares
0_5_3f800000_3f800000_b_00000001_0
0_5_00000000_80000000_c_00000001_0
0_5_7f800001_3f800000_d_00000000_1
0_6_bf800000_3f800000_e_00000001_0
0_6_7fc00000_3f800000_f_00000000_1
0_7_80000000_00000000_0_00000001_0
0_7_40000000_3f800000_1_00000000_0
2_0_00000000_00000000_0_00000000_0
// Flush with ops in flight, then reuse of a flushed tag
0_4_7f800001_7fc00000_2_7fc00000_1
0_0_3f800000_c0000000_3_bf800000_0
0_6_c0000000_bf800000_4_00000001_0
1_0_00000000_00000000_0_00000000_0
0_7_c0000000_bf800000_2_00000001_0
0_5_7fc00000_3f800000_5_00000000_0
2_0_00000000_00000000_0_00000000_0
f_0_00000000_00000000_0_00000000_0

// ==== fpu_exec_top.f ====
rtl/fpu_pkg.sv
rtl/fpu_issue_queue.sv
rtl/fpu_eu.sv
rtl/fpu_result_arb.sv
rtl/fpu_exec_top.sv
dv/fpu_exec_sva.sv
dv/fpu_exec_tb.sv

// ==== rtl/fpu_eu.sv ====
module fpu_eu (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 flush_i,

    // From the issue queue
    input  logic                 valid_i,
    input  fpu_pkg::fpu_issue_t  op_i,
    output logic                 ready_o,

    // To the result arbiter
    output logic                 valid_o,
    output fpu_pkg::fpu_result_t res_o,
    input  logic                 ready_i
);

    // Stage 1 holds the accepted op
    logic                 s1_valid_q;
    fpu_pkg::fpu_issue_t  s1_op_q;

    // Stage 2 holds the finished result
    logic                 s2_valid_q;
    fpu_pkg::fpu_result_t s2_res_q;

    logic                 s2_free;
    logic                 s1_adv;
    logic                 accept;

    // Operand decode
    fpu_pkg::fp32_u       a;
    fpu_pkg::fp32_u       b;
    logic                 a_nan;
    logic                 b_nan;
    logic                 a_snan;
    logic                 b_snan;
    logic                 any_nan;
    logic                 any_snan;
    logic                 both_zero;
    logic                 mag_lt;
    logic                 mag_gt;
    logic                 op_eq;
    logic                 op_lt;
    logic                 ord_lt;
    fpu_pkg::fpu_result_t res_d;

    // Pipeline flow
    assign s2_free = !s2_valid_q || ready_i;
    assign s1_adv  = s1_valid_q && s2_free;
    assign ready_o = !s1_valid_q || s1_adv;
    assign accept  = valid_i && ready_o;

    assign a = s1_op_q.rs1;
    assign b = s1_op_q.rs2;

    // All-ones exponent with nonzero mantissa
    assign a_nan  = (a.fields.exponent == 8'hff) && (a.fields.mantissa != '0);
    assign b_nan  = (b.fields.exponent == 8'hff) && (b.fields.mantissa != '0);
    // Quiet bit clear marks a signalling NaN
    assign a_snan = a_nan && !a.fields.mantissa[22];
    assign b_snan = b_nan && !b.fields.mantissa[22];

    assign any_nan   = a_nan || b_nan;
    assign any_snan  = a_snan || b_snan;
    // +0 and -0 in any combination
    assign both_zero = (a.raw[30:0] == '0) && (b.raw[30:0] == '0);

    // Magnitude order straight from the raw bits
    assign mag_lt = a.raw[30:0] < b.raw[30:0];
    assign mag_gt = a.raw[30:0] > b.raw[30:0];

    // IEEE equality, zeros compare equal
    assign op_eq = (a.raw == b.raw) || both_zero;

    // Signed less-than for non-NaN operands
    always_comb begin
        if (both_zero) begin
            op_lt = 1'b0;
        end else if (a.fields.sign != b.fields.sign) begin
            op_lt = a.fields.sign;
        end else if (a.fields.sign) begin
            // Both negative, larger magnitude is smaller
            op_lt = mag_gt;
        end else begin
            op_lt = mag_lt;
        end
    end

    // Min/max order also ranks -0 below +0
    assign ord_lt = op_lt || (both_zero && a.fields.sign && !b.fields.sign);

    always_comb begin
        res_d.tag     = s1_op_q.tag;
        res_d.value   = '0;
        res_d.invalid = 1'b0;
        unique case (s1_op_q.op)
            fpu_pkg::OP_SGNJ: begin
                res_d.value = {b.fields.sign, a.raw[30:0]};
            end
            fpu_pkg::OP_SGNJN: begin
                res_d.value = {~b.fields.sign, a.raw[30:0]};
            end
            fpu_pkg::OP_SGNJX: begin
                res_d.value = {a.fields.sign ^ b.fields.sign, a.raw[30:0]};
            end
            fpu_pkg::OP_MIN, fpu_pkg::OP_MAX: begin
                res_d.invalid = any_snan;
                if (a_nan && b_nan) begin
                    res_d.value = fpu_pkg::CANON_NAN;
                end else if (a_nan) begin
                    res_d.value = b.raw;
                end else if (b_nan) begin
                    res_d.value = a.raw;
                end else if (s1_op_q.op == fpu_pkg::OP_MIN) begin
                    res_d.value = ord_lt ? a.raw : b.raw;
                end else begin
                    res_d.value = ord_lt ? b.raw : a.raw;
                end
            end
            fpu_pkg::OP_FEQ: begin
                // Quiet compare, only sNaN is invalid
                res_d.value   = {31'd0, !any_nan && op_eq};
                res_d.invalid = any_snan;
            end
            fpu_pkg::OP_FLT: begin
                res_d.value   = {31'd0, !any_nan && op_lt};
                res_d.invalid = any_nan;
            end
            fpu_pkg::OP_FLE: begin
                res_d.value   = {31'd0, !any_nan && (op_lt || op_eq)};
                res_d.invalid = any_nan;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else if (flush_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            // Stage 1 refills in the cycle it moves on
            if (accept) begin
                s1_valid_q <= 1'b1;
            end else if (s1_adv) begin
                s1_valid_q <= 1'b0;
            end
            // Stage 2 empties only when taken and not refilled
            if (s1_adv) begin
                s2_valid_q <= 1'b1;
            end else if (ready_i) begin
                s2_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            s1_op_q <= op_i;
        end
        if (s1_adv) begin
            s2_res_q <= res_d;
        end
    end

    assign valid_o = s2_valid_q;
    assign res_o   = s2_res_q;

endmodule

// ==== rtl/fpu_exec_top.sv ====
module fpu_exec_top #(
    parameter int RS_DEPTH = 4,
    parameter int N_EU     = 2
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 flush_i,

    // Issue port
    input  logic                 issue_valid_i,
    input  fpu_pkg::fpu_issue_t  issue_i,
    output logic                 issue_ready_o,

    // Result port
    output logic                 res_valid_o,
    output fpu_pkg::fpu_result_t res_o,
    input  logic                 res_ready_i
);

    // Queue to units
    logic                 [N_EU-1:0] disp_valid;
    logic                 [N_EU-1:0] disp_ready;
    fpu_pkg::fpu_issue_t             disp_op;

    // Units to arbiter
    logic                 [N_EU-1:0] eu_valid;
    logic                 [N_EU-1:0] eu_ready;
    fpu_pkg::fpu_result_t [N_EU-1:0] eu_res;

    fpu_issue_queue #(
        .RS_DEPTH (RS_DEPTH),
        .N_EU     (N_EU)
    ) u_queue (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .issue_ready_o (issue_ready_o),
        .disp_valid_o  (disp_valid),
        .disp_op_o     (disp_op),
        .disp_ready_i  (disp_ready)
    );

    // Identical units share the dispatch bus
    for (genvar i = 0; i < N_EU; i++) begin : g_eu
        fpu_eu u_eu (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .flush_i (flush_i),
            .valid_i (disp_valid[i]),
            .op_i    (disp_op),
            .ready_o (disp_ready[i]),
            .valid_o (eu_valid[i]),
            .res_o   (eu_res[i]),
            .ready_i (eu_ready[i])
        );
    end

    fpu_result_arb #(
        .N_EU (N_EU)
    ) u_arb (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .eu_valid_i  (eu_valid),
        .eu_res_i    (eu_res),
        .eu_ready_o  (eu_ready),
        .res_valid_o (res_valid_o),
        .res_o       (res_o),
        .res_ready_i (res_ready_i)
    );

endmodule

// ==== rtl/fpu_issue_queue.sv ====
module fpu_issue_queue #(
    parameter int RS_DEPTH = 4,
    parameter int N_EU     = 2
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,

    // Issue side
    input  logic                issue_valid_i,
    input  fpu_pkg::fpu_issue_t issue_i,
    output logic                issue_ready_o,

    // Dispatch side, one handshake pair per unit
    output logic [N_EU-1:0]     disp_valid_o,
    output fpu_pkg::fpu_issue_t disp_op_o,
    input  logic [N_EU-1:0]     disp_ready_i
);

    localparam int PTR_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;
    localparam int CNT_W = $clog2(RS_DEPTH + 1);

    // Entry storage
    fpu_pkg::fpu_issue_t mem_q [RS_DEPTH];

    // Circular buffer control
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;

    logic             push;
    logic             pop;
    logic [N_EU-1:0]  pick;

    // Pointer increment with wrap at the last entry
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(RS_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // Free entry available, nothing accepted while flushing
    assign issue_ready_o = (count_q != CNT_W'(RS_DEPTH)) && !flush_i;
    assign push          = issue_valid_i && issue_ready_o;

    // Isolate lowest set bit of the ready vector
    assign pick = disp_ready_i & (~disp_ready_i + N_EU'(1));

    // Offer the head only to the chosen unit
    assign disp_valid_o = ((count_q != '0) && !flush_i) ? pick : '0;
    assign disp_op_o    = mem_q[head_q];

    // Head leaves when the selected unit takes it
    assign pop = |(disp_valid_o & disp_ready_i);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            // Drop every buffered entry
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                tail_q <= next_ptr(tail_q);
            end
            if (pop) begin
                head_q <= next_ptr(head_q);
            end
            // Occupancy follows push and pop together
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Payload write at the tail
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[tail_q] <= issue_i;
        end
    end

endmodule

// ==== rtl/fpu_pkg.sv ====
package fpu_pkg;

    // Reorder-buffer tag width, fixed by the ROB
    localparam int TAG_W = 4;

    // Canonical quiet NaN returned when both min/max operands are NaN
    localparam logic [31:0] CANON_NAN = 32'h7fc0_0000;

    // Operation codes handled by the execution units
    typedef enum logic [2:0] {
        OP_SGNJ  = 3'd0,
        OP_SGNJN = 3'd1,
        OP_SGNJX = 3'd2,
        OP_MIN   = 3'd3,
        OP_MAX   = 3'd4,
        OP_FEQ   = 3'd5,
        OP_FLT   = 3'd6,
        OP_FLE   = 3'd7
    } fpu_op_e;

    // IEEE-754 single-precision layout
    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] mantissa;
    } fp32_fields_t;

    // Operand word, seen as a raw word or as its fields
    // Fields serve the NaN, zero and sign tests
    // The raw word serves magnitude compares
    typedef union packed {
        logic [31:0]  raw;
        fp32_fields_t fields;
    } fp32_u;

    // Instruction with resolved operands, as issued by the core
    typedef struct packed {
        fpu_op_e          op;
        fp32_u            rs1;
        fp32_u            rs2;
        logic [TAG_W-1:0] tag;
    } fpu_issue_t;

    // Tagged result for out-of-order write back
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [31:0]      value;
        logic             invalid;
    } fpu_result_t;

endpackage

// ==== rtl/fpu_result_arb.sv ====
module fpu_result_arb #(
    parameter int N_EU = 2
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                flush_i,

    // Unit results
    input  logic                 [N_EU-1:0]     eu_valid_i,
    input  fpu_pkg::fpu_result_t [N_EU-1:0]     eu_res_i,
    output logic                 [N_EU-1:0]     eu_ready_o,

    // Shared result bus
    output logic                                res_valid_o,
    output fpu_pkg::fpu_result_t                res_o,
    input  logic                                res_ready_i
);

    localparam int IDX_W = (N_EU > 1) ? $clog2(N_EU) : 1;

    // Round-robin start position
    logic [IDX_W-1:0] rr_ptr_q;

    logic             slot_free;
    logic             gnt_any;
    logic [IDX_W-1:0] gnt_idx;

    // Slot can take a new result when empty or leaving this cycle
    assign slot_free = !res_valid_o || res_ready_i;

    // First valid unit at or after the pointer
    always_comb begin
        int idx;
        gnt_any = 1'b0;
        gnt_idx = '0;
        for (int i = 0; i < N_EU; i++) begin
            idx = int'(rr_ptr_q) + i;
            if (idx >= N_EU) begin
                idx = idx - N_EU;
            end
            if (!gnt_any && eu_valid_i[idx]) begin
                gnt_any = 1'b1;
                gnt_idx = IDX_W'(idx);
            end
        end
    end

    // Only the winner sees ready
    always_comb begin
        eu_ready_o = '0;
        if (gnt_any && slot_free && !flush_i) begin
            eu_ready_o[gnt_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_o <= 1'b0;
            rr_ptr_q    <= '0;
        end else if (flush_i) begin
            res_valid_o <= 1'b0;
        end else if (gnt_any && slot_free) begin
            res_valid_o <= 1'b1;
            // Skip past the winner for fairness
            if (gnt_idx == IDX_W'(N_EU - 1)) begin
                rr_ptr_q <= '0;
            end else begin
                rr_ptr_q <= gnt_idx + 1'b1;
            end
        end else if (res_ready_i) begin
            res_valid_o <= 1'b0;
        end
    end

    // Result payload
    always_ff @(posedge clk_i) begin
        if (gnt_any && slot_free && !flush_i) begin
            res_o <= eu_res_i[gnt_idx];
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run with Verilator, then look for the pass line in the output
cd "$(dirname "$0")" &&
    verilator --binary --assert -Wno-fatal -j 0 --top-module fpu_exec_tb -f fpu_exec_top.f &&
    out=$(./obj_dir/Vfpu_exec_tb) ||
    out="build or run error"
echo "$out"
echo "$out" | grep -q "Simulation PASSED" && echo "Run passed" || { echo "Run failed"; exit 1; }
